// File: hdl/eg_pkg.sv
/* envelope generator package: slot sizes, credit depth, phase encoding,
   slot config, config write and output sample structs */
package eg_pkg;

	localparam int NUM_SLOTS = 4;             // operator slots per voice
	localparam int SLOT_W    = 2;             // slot index width
	localparam int CREDITS   = 4;             // downstream buffer depth
	localparam int CRED_W    = 3;             // holds 0..CREDITS
	localparam int TIME_W    = 16;            // envelope time counter
	localparam logic [9:0] EG_MAX = 10'h3ff;  // silent

	// one-hot phases, release is all zeros
	typedef enum logic [2:0] {
		RELEASE = 3'b000,
		ATTACK  = 3'b001,
		DECAY   = 3'b010,
		HOLD    = 3'b100
	} eg_phase_t;

	// per-slot registers, 36 bits
	typedef struct packed {
		logic [8:0] pad;     // spare
		logic [4:0] arate;   // attack rate
		logic [4:0] rate1;   // decay rate
		logic [4:0] rate2;   // sustain rate
		logic [3:0] rrate;   // release rate, low bit forced to 1
		logic [3:0] sl;      // sustain level, 15 means 31
		logic       ssg_en;  // repeating envelope on
		logic [2:0] ssg_eg;  // attack inv, alternate, hold
	} eg_cfg_t;

	// one write from the host side
	typedef struct packed {
		logic [SLOT_W-1:0] slot;
		eg_cfg_t           cfg;
		logic              keyon;
		logic              keyoff;
	} eg_wr_t;

	// one envelope sample to the operator stage
	typedef struct packed {
		logic [SLOT_W-1:0] slot;
		logic [9:0]        atten;   // after SSG inversion
		eg_phase_t         phase;
		logic              pg_rst;  // restart phase generator
	} eg_sample_t;

endpackage

// File: hdl/eg_regs.sv
/* eg_regs: per-slot config array and pending key-on/key-off commands */
`timescale 1ns/1ps

module eg_regs import eg_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              wr_en,
	input  eg_wr_t            wr,
	input  logic              go,
	input  logic [SLOT_W-1:0] cur_slot,
	output eg_cfg_t           cfg,
	output logic              keyon_now,
	output logic              keyoff_now
);

	eg_cfg_t              cfg_mem [NUM_SLOTS];  // one entry per slot
	logic [NUM_SLOTS-1:0] keyon_pend;            // waiting for slot visit
	logic [NUM_SLOTS-1:0] keyoff_pend;

	assign cfg = cfg_mem[cur_slot];  // read before this cycle's write lands

	// key-on has priority when both are waiting
	assign keyon_now  = go & keyon_pend[cur_slot];
	assign keyoff_now = go & keyoff_pend[cur_slot] & ~keyon_pend[cur_slot];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			keyon_pend  <= '0;
			keyoff_pend <= '0;
			for (int i = 0; i < NUM_SLOTS; i++) begin
				cfg_mem[i] <= '0;  // release at rate 1
			end
		end else begin
			if (go) begin
				keyon_pend[cur_slot]  <= 1'b0;  // consumed by this visit
				keyoff_pend[cur_slot] <= 1'b0;
			end
			// a new command in the same cycle waits for the next visit
			if (wr_en) begin
				cfg_mem[wr.slot] <= wr.cfg;
				if (wr.keyon) begin
					keyon_pend[wr.slot] <= 1'b1;
				end
				if (wr.keyoff) begin
					keyoff_pend[wr.slot] <= 1'b1;
				end
			end
		end
	end

	// a key-on written during its slot's visit survives the clear
	a_keyon_kept: assert property (
		@(posedge clk) disable iff (!rst_n)
		wr_en && wr.keyon |=> keyon_pend[$past(wr.slot)]
	) else $error("eg_regs: key-on write lost");

endmodule

// File: hdl/eg_ctrl.sv
/* eg_ctrl: next phase, base rate, SSG inversion and phase-generator reset
   for the slot under processing */
`timescale 1ns/1ps

module eg_ctrl import eg_pkg::*; (
	input  logic      keyon_now,
	input  logic      keyoff_now,
	input  eg_phase_t phase_in,
	input  logic [9:0] eg,         // stored attenuation
	input  eg_cfg_t   cfg,
	input  logic      ssg_inv_in,
	output logic      ssg_inv_out,
	output logic [4:0] base_rate,
	output eg_phase_t state_next,
	output logic      pg_rst
);

	logic [4:0] sustain;   // compared against eg[9:5]
	logic       ssg_att;   // attack inversion
	logic       ssg_alt;   // alternate on overflow
	logic       ssg_hold;  // stop on overflow
	logic       ssg_over;  // eg crossed 10'h200

	assign ssg_att  = cfg.ssg_eg[2];
	assign ssg_alt  = cfg.ssg_eg[1];
	assign ssg_hold = cfg.ssg_eg[0] & cfg.ssg_en;

	assign sustain  = (cfg.sl == 4'd15) ? 5'h1f : {1'b0, cfg.sl};  // 15 is the floor
	assign ssg_over = cfg.ssg_en & eg[9];

	// overflow with plain repeat restarts the phase generator too
	assign pg_rst = keyon_now | (ssg_over & ~(ssg_alt | ssg_hold));

	always_comb begin
		base_rate   = {cfg.rrate, 1'b1};  // release unless told otherwise
		state_next  = RELEASE;
		ssg_inv_out = 1'b0;               // release drops inversion
		if (keyon_now) begin
			base_rate   = cfg.arate;
			state_next  = ATTACK;
			ssg_inv_out = ssg_att & cfg.ssg_en;
		end else if (!keyoff_now) begin
			case (phase_in)
				ATTACK: begin
					base_rate   = (eg == 10'd0) ? cfg.rate1 : cfg.arate;
					state_next  = (eg == 10'd0) ? DECAY : ATTACK;  // peak reached
					ssg_inv_out = ssg_inv_in & cfg.ssg_en;
				end
				DECAY: begin
					if (ssg_over) begin
						base_rate   = ssg_hold ? 5'd0 : cfg.arate;
						state_next  = ssg_hold ? HOLD : ATTACK;       // repeat or stop
						ssg_inv_out = cfg.ssg_en & (ssg_alt ^ ssg_inv_in);
					end else begin
						base_rate   = (eg[9:5] >= sustain) ? cfg.rate2 : cfg.rate1;
						state_next  = DECAY;
						ssg_inv_out = ssg_inv_in & cfg.ssg_en;
					end
				end
				HOLD: begin
					base_rate   = 5'd0;  // frozen
					state_next  = HOLD;
					ssg_inv_out = ssg_inv_in & cfg.ssg_en;
				end
				default: begin
					base_rate   = {cfg.rrate, 1'b1};  // stays in release
					state_next  = RELEASE;
					ssg_inv_out = 1'b0;
				end
			endcase
		end
	end

endmodule

// File: hdl/eg_rate.sv
/* eg_rate: envelope time counter and the step enable and step size rule */
`timescale 1ns/1ps

module eg_rate import eg_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              go,
	input  logic [SLOT_W-1:0] cur_slot,
	input  logic [4:0]        base_rate,
	output logic              step_en,
	output logic [3:0]        step_size
);

	logic [TIME_W-1:0] time_cnt;  // one tick per full slot round
	logic [4:0]        inv_rate;  // 31 - rate
	logic [2:0]        shift;     // low counter bits that must be zero
	logic [TIME_W-1:0] mask;

	// time moves only when the last slot is processed
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			time_cnt <= '0;
		end else if (go && cur_slot == SLOT_W'(NUM_SLOTS - 1)) begin
			time_cnt <= time_cnt + 1'b1;
		end
	end

	always_comb begin
		inv_rate  = 5'd31 - base_rate;
		shift     = inv_rate[4:2];                           // 0..7
		mask      = (TIME_W'(1) << shift) - TIME_W'(1);
		step_en   = (base_rate != 5'd0) && ((time_cnt & mask) == '0);  // rate 0 is frozen
		step_size = 4'd1 + {2'b00, base_rate[1:0]};          // 1..4 per step
	end

endmodule

// File: hdl/eg_step.sv
/* eg_step: slot sequencer, credit counter, per-slot phase/attenuation/inversion
   storage, attenuation update and output sample register */
`timescale 1ns/1ps

module eg_step import eg_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              credit_ret,   // one credit back per cycle
	output logic              go,           // process cur_slot now
	output logic [SLOT_W-1:0] cur_slot,
	output eg_phase_t         phase,        // stored state of cur_slot
	output logic [9:0]        eg,
	output logic              ssg_inv,
	input  eg_phase_t         state_next,
	input  logic              ssg_inv_out,
	input  logic              pg_rst,
	input  logic              step_en,
	input  logic [3:0]        step_size,
	output logic              out_valid,
	output eg_sample_t        out_sample
);

	logic [CRED_W-1:0]    credits;               // free downstream entries
	eg_phase_t            phase_mem [NUM_SLOTS];
	logic [9:0]           eg_mem    [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] inv_mem;               // SSG output inversion
	logic [10:0]          att_dn;                // attack step, sign in bit 10
	logic [10:0]          rel_up;                // decay/release step, carry in bit 10
	logic [9:0]           eg_new;
	logic [9:0]           atten_out;

	assign go      = (credits != '0);  // stalls everything when empty
	assign phase   = phase_mem[cur_slot];
	assign eg      = eg_mem[cur_slot];
	assign ssg_inv = inv_mem[cur_slot];

	always_comb begin
		att_dn = {1'b0, eg} - {5'd0, eg[9:4]} - {7'd0, step_size};  // exponential approach
		rel_up = {1'b0, eg} + {7'd0, step_size};
		eg_new = eg;  // phase changes and key-on keep the level
		if (step_en && state_next == phase) begin
			case (state_next)
				ATTACK:         eg_new = att_dn[10] ? 10'd0 : att_dn[9:0];  // floor at 0
				DECAY, RELEASE: eg_new = (rel_up > {1'b0, EG_MAX}) ? EG_MAX : rel_up[9:0];
				default:        eg_new = eg;                               // hold
			endcase
		end
		// inverted around 10'h200, wraps to 10 bits
		atten_out = ssg_inv_out ? (10'h200 - eg_new) : eg_new;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credits   <= CRED_W'(CREDITS);
			cur_slot  <= '0;
			inv_mem   <= '0;
			out_valid <= 1'b0;
			for (int i = 0; i < NUM_SLOTS; i++) begin
				phase_mem[i] <= RELEASE;
				eg_mem[i]    <= EG_MAX;  // silent
			end
		end else begin
			case ({go, credit_ret})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;  // none, or take and return
			endcase
			out_valid <= go;  // sample one cycle after processing
			if (go) begin
				phase_mem[cur_slot] <= state_next;
				eg_mem[cur_slot]    <= eg_new;
				inv_mem[cur_slot]   <= ssg_inv_out;
				cur_slot <= (cur_slot == SLOT_W'(NUM_SLOTS - 1)) ? '0 : cur_slot + 1'b1;
			end
		end
	end

	// sample payload, qualified by out_valid
	always_ff @(posedge clk) begin
		if (go) begin
			out_sample.slot   <= cur_slot;
			out_sample.atten  <= atten_out;
			out_sample.phase  <= state_next;
			out_sample.pg_rst <= pg_rst;
		end
	end

	// downstream must not hand back more than it was given
	a_credit_max: assert property (
		@(posedge clk) disable iff (!rst_n)
		credits <= CRED_W'(CREDITS)
	) else $error("eg_step: credit count above buffer depth");

endmodule

// File: hdl/eg_top.sv
/* eg_top: envelope generator top, config regs, phase control, rate and step blocks */
`timescale 1ns/1ps

module eg_top import eg_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       wr_en,
	input  eg_wr_t     wr,
	input  logic       credit_ret,
	output logic       out_valid,
	output eg_sample_t out_sample
);

	logic              go;           // slot processed this cycle
	logic [SLOT_W-1:0] cur_slot;
	eg_cfg_t           cfg;          // cfg of cur_slot
	logic              keyon_now;
	logic              keyoff_now;
	eg_phase_t         phase;        // stored phase of cur_slot
	logic [9:0]        eg;
	logic              ssg_inv;
	eg_phase_t         state_next;
	logic              ssg_inv_out;
	logic              pg_rst;
	logic [4:0]        base_rate;
	logic              step_en;
	logic [3:0]        step_size;

	eg_regs i_eg_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.wr         (wr),
		.go         (go),
		.cur_slot   (cur_slot),
		.cfg        (cfg),
		.keyon_now  (keyon_now),
		.keyoff_now (keyoff_now)
	);

	eg_ctrl i_eg_ctrl (
		.keyon_now   (keyon_now),
		.keyoff_now  (keyoff_now),
		.phase_in    (phase),
		.eg          (eg),
		.cfg         (cfg),
		.ssg_inv_in  (ssg_inv),
		.ssg_inv_out (ssg_inv_out),
		.base_rate   (base_rate),
		.state_next  (state_next),
		.pg_rst      (pg_rst)
	);

	eg_rate i_eg_rate (
		.clk       (clk),
		.rst_n     (rst_n),
		.go        (go),
		.cur_slot  (cur_slot),
		.base_rate (base_rate),
		.step_en   (step_en),
		.step_size (step_size)
	);

	eg_step i_eg_step (
		.clk         (clk),
		.rst_n       (rst_n),
		.credit_ret  (credit_ret),
		.go          (go),
		.cur_slot    (cur_slot),
		.phase       (phase),
		.eg          (eg),
		.ssg_inv     (ssg_inv),
		.state_next  (state_next),
		.ssg_inv_out (ssg_inv_out),
		.pg_rst      (pg_rst),
		.step_en     (step_en),
		.step_size   (step_size),
		.out_valid   (out_valid),
		.out_sample  (out_sample)
	);

endmodule

// File: bench/eg_model.svh
/* reference model of the four-slot envelope: per-slot state, pending key
   commands and envelope time, one predicted sample per processed slot */
`ifndef EG_MODEL_SVH
`define EG_MODEL_SVH

eg_cfg_t   m_cfg   [NUM_SLOTS];  // config as the slot will see it
eg_phase_t m_phase [NUM_SLOTS];
int        m_eg    [NUM_SLOTS];  // attenuation 0..1023
bit        m_inv   [NUM_SLOTS];  // ssg output inversion
bit        m_on    [NUM_SLOTS];  // key-on waiting for a visit
bit        m_off   [NUM_SLOTS];
int        m_time;               // rounds completed
int        m_slot;               // next slot to be processed
int        m_count;              // samples predicted

task automatic model_reset();
	for (int i = 0; i < NUM_SLOTS; i++) begin
		m_cfg[i]   = '0;
		m_phase[i] = RELEASE;
		m_eg[i]    = 1023;  // silent
		m_inv[i]   = 1'b0;
		m_on[i]    = 1'b0;
		m_off[i]   = 1'b0;
	end
	m_time  = 0;
	m_slot  = 0;
	m_count = 0;
endtask

// writes land in arrival order, after any visit in the same cycle
task automatic model_write(input eg_wr_t w);
	m_cfg[w.slot] = w.cfg;
	if (w.keyon) m_on[w.slot] = 1'b1;
	if (w.keyoff) m_off[w.slot] = 1'b1;
endtask

// rate r fires once every 2^((31-r)/4) rounds, never at 0
function automatic bit rate_fires(input int rate, input int t);
	int period;
	if (rate == 0) return 1'b0;
	period = 1 << ((31 - rate) / 4);
	return (t % period) == 0;
endfunction

task automatic model_next(output eg_sample_t s);
	eg_cfg_t   c;
	eg_phase_t ph;
	eg_phase_t nph;
	int        idx;
	int        rate;
	int        lvl;
	int        v;
	int        sl_top;
	bit        kon;
	bit        koff;
	bit        over;
	bit        hold;
	bit        alt;
	bit        ninv;
	idx  = m_slot;
	c    = m_cfg[idx];
	ph   = m_phase[idx];
	lvl  = m_eg[idx];
	kon  = m_on[idx];
	koff = m_off[idx] && !kon;  // key-on wins, key-off dropped
	m_on[idx]  = 1'b0;
	m_off[idx] = 1'b0;
	sl_top = (c.sl == 4'd15) ? 31 : int'(c.sl);
	over   = c.ssg_en && lvl >= 512;
	hold   = c.ssg_en && c.ssg_eg[0];
	alt    = c.ssg_eg[1];
	nph    = RELEASE;  // default release, rrate*2+1
	rate   = int'(c.rrate) * 2 + 1;
	ninv   = 1'b0;
	if (kon) begin
		nph  = ATTACK;
		rate = int'(c.arate);
		ninv = c.ssg_en && c.ssg_eg[2];
	end else if (!koff && ph == ATTACK) begin
		nph  = (lvl == 0) ? DECAY : ATTACK;
		rate = (lvl == 0) ? int'(c.rate1) : int'(c.arate);
		ninv = m_inv[idx] && c.ssg_en;
	end else if (!koff && ph == DECAY && over) begin
		nph  = hold ? HOLD : ATTACK;  // ssg repeat
		rate = hold ? 0 : int'(c.arate);
		ninv = c.ssg_en && (alt ^ m_inv[idx]);
	end else if (!koff && ph == DECAY) begin
		nph  = DECAY;
		rate = ((lvl >> 5) >= sl_top) ? int'(c.rate2) : int'(c.rate1);
		ninv = m_inv[idx] && c.ssg_en;
	end else if (!koff && ph == HOLD) begin
		nph  = HOLD;
		rate = 0;
		ninv = m_inv[idx] && c.ssg_en;
	end
	// level moves only when the phase is kept
	if (rate_fires(rate, m_time) && nph == ph) begin
		if (nph == ATTACK) begin
			v   = lvl - (lvl >> 4) - (1 + rate % 4);
			lvl = (v < 0) ? 0 : v;
		end else if (nph != HOLD) begin
			v   = lvl + 1 + rate % 4;
			lvl = (v > 1023) ? 1023 : v;
		end
	end
	m_phase[idx] = nph;
	m_eg[idx]    = lvl;
	m_inv[idx]   = ninv;
	s.slot   = SLOT_W'(idx);
	s.atten  = ninv ? 10'((512 - lvl) & 1023) : 10'(lvl);
	s.phase  = nph;
	s.pg_rst = kon || (over && !hold && !alt);
	if (idx == NUM_SLOTS - 1) m_time = (m_time + 1) % 65536;
	m_slot  = (idx + 1) % NUM_SLOTS;
	m_count = m_count + 1;
endtask

`endif

// File: bench/eg_tb.sv
/* testbench for the envelope generator: clock, reset, LFSR stimulus,
   credit return, watchdog, compare tasks and result report */
`timescale 1ns/1ps

module eg_tb import eg_pkg::*; ();

	localparam int PERIOD     = 40;     // ns
	localparam int RUN_CYCLES = 24000;  // random stimulus length
	localparam int WATCHDOG   = (RUN_CYCLES + 64) * 4 * PERIOD;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       wr_en;
	eg_wr_t     wr;
	logic       credit_ret;
	logic       out_valid;
	eg_sample_t out_sample;

	logic [31:0] lfsr = 32'h0d9e6d61;
	bit          mon_en;        // monitor running
	bit          drv_en;        // stimulus running
	bit          draining;      // no more writes or returns
	int          n_samples;     // samples seen
	int          n_ret;         // returns sampled by the DUT
	int          n_ret_driven;  // returns put on the wire
	int          stall_left;    // cycles of forced back-pressure
	int          n_hold;
	int          n_pg;
	int          n_inv;
	bit          wr_seen;       // write sampled at the coming edge
	eg_wr_t      wr_seen_val;
	bit          ret_seen;

	`include "eg_model.svh"

	eg_top i_eg_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.wr         (wr),
		.credit_ret (credit_ret),
		.out_valid  (out_valid),
		.out_sample (out_sample)
	);

	always #(PERIOD / 2) clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	function automatic string sample_text(input eg_sample_t s);
		return $sformatf("slot %0d atten %h phase %b pg_rst %b", s.slot, s.atten, s.phase,
			s.pg_rst);
	endfunction

	task automatic check_sample(input string name, input eg_sample_t exp, input eg_sample_t act);
		if (exp !== act) begin
			abort_run($sformatf("CHECK FAILED %s: expected %s, actual %s", name,
				sample_text(exp), sample_text(act)));
		end
	endtask

	task automatic check_phase(input string name, input eg_phase_t exp, input eg_phase_t act);
		if (exp !== act) begin
			abort_run($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			abort_run($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act));
		end
	endtask

	// taps 32 22 2 1, one step per bit
	function automatic bit lfsr_bit();
		bit fb;
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_bit());
		end
		return v;
	endfunction

	// fast attack and decay so envelopes finish between writes
	function automatic eg_wr_t random_write();
		eg_wr_t w;
		int     kind;
		w            = '0;
		w.slot       = SLOT_W'(take_bits(SLOT_W));
		w.cfg.arate  = {2'b11, 3'(take_bits(3))};
		w.cfg.rate1  = {2'b11, 3'(take_bits(3))};
		w.cfg.rate2  = 5'(take_bits(5));
		w.cfg.rrate  = {1'b1, 3'(take_bits(3))};
		w.cfg.sl     = 4'(take_bits(4));
		w.cfg.ssg_en = 1'(take_bits(1));
		w.cfg.ssg_eg = 3'(take_bits(3));
		kind         = take_bits(2);  // cfg only, on, off, both
		w.keyon      = (kind == 1 || kind == 3);
		w.keyoff     = (kind == 2 || kind == 3);
		return w;
	endfunction

	// stimulus, driven on the rising edge
	always @(posedge clk) begin
		if (drv_en) begin
			if (!draining && n_samples >= NUM_SLOTS && take_bits(9) == 0) begin
				wr_en <= 1'b1;
				wr    <= random_write();
			end else begin
				wr_en <= 1'b0;
			end
			if (stall_left > 0) begin
				stall_left = stall_left - 1;
			end else if (take_bits(6) == 0) begin
				stall_left = 8 + take_bits(5);  // back-pressure burst
			end
			// only hand back what was received
			if (!draining && stall_left == 0 && n_samples > n_ret_driven && take_bits(1) == 1) begin
				credit_ret   <= 1'b1;
				n_ret_driven = n_ret_driven + 1;
			end else begin
				credit_ret <= 1'b0;
			end
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin : monitor
		eg_sample_t exp;
		int         cred_before;
		if (mon_en) begin
			cred_before = CREDITS - n_samples + n_ret;  // DUT credits before last edge
			check_count("valid follows credits", int'(cred_before != 0), int'(out_valid));
			if (out_valid) begin
				if (n_samples < NUM_SLOTS) begin
					check_phase("release after reset", RELEASE, out_sample.phase);
					check_count("silent after reset", int'(EG_MAX), int'(out_sample.atten));
					check_count("slot order after reset", n_samples, int'(out_sample.slot));
				end
				model_next(exp);
				check_sample("envelope sample", exp, out_sample);
				n_samples = n_samples + 1;
				if (n_samples - n_ret > CREDITS) begin
					abort_run("more samples in flight than the downstream buffer holds");
				end
				if (exp.phase == HOLD) n_hold = n_hold + 1;
				if (exp.pg_rst) n_pg = n_pg + 1;
				if (exp.atten != 10'(m_eg[exp.slot])) n_inv = n_inv + 1;
			end
			if (wr_seen) model_write(wr_seen_val);  // after this edge's visit
			if (ret_seen) n_ret = n_ret + 1;
			wr_seen     = wr_en;
			wr_seen_val = wr;
			ret_seen    = credit_ret;
		end
	end

	initial begin
		#(WATCHDOG);
		abort_run("watchdog: the run did not finish in the expected time");
	end

	initial begin : main
		int held;
		rst_n      = 1'b0;
		wr_en      = 1'b0;
		wr         = '0;
		credit_ret = 1'b0;
		model_reset();
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_count("valid low after reset", 0, int'(out_valid));
		mon_en <= 1'b1;
		drv_en <= 1'b1;
		repeat (RUN_CYCLES) @(posedge clk);
		draining <= 1'b1;
		@(posedge clk);
		// every return on the wire has reached the DUT
		while (n_ret != n_ret_driven) @(posedge clk);
		// credits left go at one slot per cycle, then everything must freeze
		repeat (CREDITS + 2) @(posedge clk);
		held = n_samples;
		repeat (8) @(posedge clk);
		check_count("no samples while stalled", held, n_samples);
		check_count("model sample count", CREDITS + n_ret, m_count);
		$display("samples %0d, hold %0d, pg_rst %0d, inverted %0d", n_samples, n_hold, n_pg,
			n_inv);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: src.f
+incdir+bench
hdl/eg_pkg.sv
hdl/eg_regs.sv
hdl/eg_ctrl.sv
hdl/eg_rate.sv
hdl/eg_step.sv
hdl/eg_top.sv
bench/eg_tb.sv

// File: Makefile
# Verilator build and run of the envelope generator testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f src.f --top-module eg_tb -o eg_sim
	./obj_dir/eg_sim 2>&1 | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
